/* common/phaseCpu_config.svh */
`ifndef PHASE_CPU_CONFIG_SVH
`define PHASE_CPU_CONFIG_SVH

// datapath and instruction sizes
`define WORD_WIDTH 9      // data word
`define INSTR_WIDTH 24    // one instruction word

// memories
`define PROG_DEPTH 32     // indexed by the low pc bits
`define REG_COUNT 8       // general registers r0..r7
`define DATA_DEPTH 16     // data words, top one is the port

// sequencing
`define PHASE_COUNT 6     // one-hot phases per slot

// io port lives in the data space
`define PORT_ADDR 4'hF

`endif

/* common/phaseCpuPkg.sv */
`include "phaseCpu_config.svh"

package phaseCpuPkg;

  typedef logic [`WORD_WIDTH-1:0] word_t;     // data word, arithmetic is modulo 512
  typedef logic [`INSTR_WIDTH-1:0] instr_t;   // full instruction
  typedef logic signed [7:0] pc_t;            // relative jumps need a signed pc
  typedef logic [2:0] regAddr_t;              // register select
  typedef logic [3:0] dataAddr_t;             // data memory select
  typedef logic [`PHASE_COUNT-1:0] phase_t;   // one-hot phase ring

  // opcode field, bits 23..20 of the instruction
  typedef enum logic [3:0] {
    NOP  = 4'h0,
    LD   = 4'h1,   // load from data memory or port
    ADD  = 4'h2,
    SUB  = 4'h3,
    INC  = 4'h4,
    DEC  = 4'h5,
    COP  = 4'h6,   // copy operand b
    MUL  = 4'h7,
    AND  = 4'h8,
    XOR  = 4'h9,
    JUMP = 4'hA,   // unconditional, one slot
    JZ   = 4'hB,   // conditional jumps take two slots
    JG   = 4'hC,
    JL   = 4'hD
  } opcode_t;

  // status from the last alu operation
  typedef struct packed {
    logic z;   // result zero
    logic l;   // a < b, signed
    logic g;   // a > b, signed
  } flags_t;

endpackage

/* fetch/fetchUnit.sv */
`timescale 1ns/1ps
`include "phaseCpu_config.svh"

module fetchUnit (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             run,
  input  logic                             progWrite,
  input  logic [$clog2(`PROG_DEPTH)-1:0]   progAddr,
  input  phaseCpuPkg::instr_t              progData,
  input  phaseCpuPkg::flags_t              flags,
  output phaseCpuPkg::phase_t              phase,
  output phaseCpuPkg::instr_t              instr
);
  import phaseCpuPkg::*;

  localparam int ProgAddrBits = $clog2(`PROG_DEPTH);

  instr_t  progMem [`PROG_DEPTH];   // loaded while run is low
  pc_t     pc;                      // signed, wraps modulo 256
  logic    pass;                    // set between the two slots of a conditional jump
  instr_t  fetched;
  opcode_t fetchedOp;
  pc_t     offset;                  // bits 19..12 of a jump
  logic    condTaken;

  assign fetched   = progMem[pc[ProgAddrBits-1:0]];  // only the low bits index memory
  assign fetchedOp = opcode_t'(fetched[23:20]);
  assign offset    = pc_t'(fetched[19:12]);

  // flag tested by the conditional jump being fetched
  always_comb
  begin
    case (fetchedOp)
      JZ:      condTaken = flags.z;
      JL:      condTaken = flags.l;
      JG:      condTaken = flags.g;
      default: condTaken = 1'b0;
    endcase
  end

  // phase ring, parks in phase 0 while run is low but finishes a started slot
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      phase <= phase_t'(1);
    else if (run || !phase[0])
      phase <= {phase[`PHASE_COUNT-2:0], phase[`PHASE_COUNT-1]};
  end

  always_ff @(posedge clk)
  begin
    if (progWrite && !run)
      progMem[progAddr] <= progData;   // loader port
  end

  always_ff @(posedge clk)
  begin
    if (run && phase[0])
      instr <= fetched;   // held for the rest of the slot
  end

  // pc update happens in phase 0 together with the fetch
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc   <= '0;
      pass <= 1'b0;
    end
    else if (run && phase[0])
    begin
      case (fetchedOp)
        JUMP: pc <= pc + offset;   // pass left as is
        JZ, JL, JG:
        begin
          if (!pass)
            pass <= 1'b1;          // first slot, pc stays on the jump
          else if (condTaken)
          begin
            pc   <= pc + offset;
            pass <= 1'b0;
          end
          else
            pc <= pc + pc_t'(1);   // fall through to the next word
        end
        default:
        begin
          pc   <= pc + pc_t'(1);
          pass <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* rtl/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit (
  input  logic                   clk,
  input  logic                   rst,
  input  phaseCpuPkg::phase_t    phase,
  input  phaseCpuPkg::instr_t    instr,
  output phaseCpuPkg::regAddr_t  wAddr,
  output phaseCpuPkg::regAddr_t  rAddr,
  output phaseCpuPkg::dataAddr_t dAddr,
  output logic                   regDat,
  output logic                   regOp,
  output logic                   rdNwrt,
  output phaseCpuPkg::opcode_t   aluControl
);
  import phaseCpuPkg::*;

  opcode_t instrOp;
  opcode_t opcode;   // registered in phase 1
  logic    isJump;

  assign instrOp = opcode_t'(instr[23:20]);
  assign isJump  = instrOp inside {JUMP, JZ, JG, JL};

  // address fields, phase 1
  always_ff @(posedge clk)
  begin
    if (phase[1])
    begin
      wAddr  <= instr[18:16];   // also operand a
      rAddr  <= instr[14:12];   // operand b
      regDat <= instr[15];      // 1 alu result, 0 data word
      dAddr  <= instr[11:8];
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      opcode     <= NOP;
      regOp      <= 1'b0;
      rdNwrt     <= 1'b1;
      aluControl <= NOP;
    end
    else
    begin
      if (phase[1])
      begin
        opcode <= instrOp;
        regOp  <= isJump ? 1'b0 : instr[6];   // offset bits overlap these fields
        rdNwrt <= isJump ? 1'b1 : instr[5];   // a jump never writes memory
      end
      if (phase[2])
      begin
        case (opcode)
          ADD, SUB, INC, DEC, COP, MUL, AND, XOR: aluControl <= opcode;
          default: aluControl <= NOP;   // LD, jumps, unused codes
        endcase
      end
    end
  end

endmodule

/* datapath/registerFile.sv */
`timescale 1ns/1ps
`include "phaseCpu_config.svh"

module registerFile (
  input  logic                  clk,
  input  phaseCpuPkg::phase_t   phase,
  input  phaseCpuPkg::regAddr_t wAddr,
  input  phaseCpuPkg::regAddr_t rAddr,
  input  logic                  regDat,
  input  logic                  regOp,
  input  phaseCpuPkg::word_t    result,
  input  phaseCpuPkg::word_t    dataWord,
  output phaseCpuPkg::word_t    opA,
  output phaseCpuPkg::word_t    opB
);
  import phaseCpuPkg::*;

  word_t regs [`REG_COUNT];   // r0..r7, programs load their own values

  // operand read in phase 2
  always_ff @(posedge clk)
  begin
    if (phase[2])
    begin
      opA <= regs[wAddr];   // destination doubles as operand a
      opB <= regs[rAddr];
    end
  end

  // write-back in phase 5, after alu and memory have settled
  always_ff @(posedge clk)
  begin
    if (phase[5] && regOp)
      regs[wAddr] <= regDat ? result : dataWord;
  end

endmodule

/* datapath/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic                 clk,
  input  logic                 rst,
  input  phaseCpuPkg::phase_t  phase,
  input  phaseCpuPkg::opcode_t aluControl,
  input  phaseCpuPkg::word_t   opA,
  input  phaseCpuPkg::word_t   opB,
  output phaseCpuPkg::word_t   result,
  output phaseCpuPkg::flags_t  flags
);
  import phaseCpuPkg::*;

  word_t nextResult;

  // all results wrap at 9 bits
  always_comb
  begin
    case (aluControl)
      ADD:     nextResult = opA + opB;
      SUB:     nextResult = opA - opB;
      INC:     nextResult = opA + word_t'(1);
      DEC:     nextResult = opA - word_t'(1);
      COP:     nextResult = opB;
      MUL:     nextResult = opA * opB;   // low half of the unsigned product
      AND:     nextResult = opA & opB;
      XOR:     nextResult = opA ^ opB;
      default: nextResult = result;      // NOP holds
    endcase
  end

  // result and flags register in phase 3
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      result <= '0;
      flags  <= '0;
    end
    else if (phase[3])
    begin
      result <= nextResult;
      if (aluControl != NOP)
      begin
        flags.z <= (nextResult == '0);
        flags.l <= $signed(opA) < $signed(opB);   // signed compare for JL
        flags.g <= $signed(opA) > $signed(opB);
      end
    end
  end

endmodule

/* datapath/dataMemory.sv */
`timescale 1ns/1ps
`include "phaseCpu_config.svh"

module dataMemory (
  input  logic                   clk,
  input  logic                   rst,
  input  phaseCpuPkg::phase_t    phase,
  input  phaseCpuPkg::dataAddr_t dAddr,
  input  logic                   rdNwrt,
  input  phaseCpuPkg::word_t     storeData,
  input  phaseCpuPkg::word_t     portIn,
  output phaseCpuPkg::word_t     dataWord,
  output phaseCpuPkg::word_t     portOut,
  output logic                   portWrite
);
  import phaseCpuPkg::*;

  word_t mem [`DATA_DEPTH];
  logic  isPort;   // top address maps to the port

  assign isPort = (dAddr == `PORT_ADDR);

  // memory access in phase 3
  always_ff @(posedge clk)
  begin
    if (phase[3])
    begin
      if (rdNwrt)
        dataWord <= isPort ? portIn : mem[dAddr];
      else if (!isPort)
        mem[dAddr] <= storeData;
    end
  end

  // port store, strobe lasts one cycle since phase 3 does
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      portOut   <= '0;
      portWrite <= 1'b0;
    end
    else
    begin
      portWrite <= phase[3] && !rdNwrt && isPort;
      if (phase[3] && !rdNwrt && isPort)
        portOut <= storeData;   // held until the next port store
    end
  end

endmodule

/* rtl/phaseCpu.sv */
`timescale 1ns/1ps
`include "phaseCpu_config.svh"

module phaseCpu (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             run,
  input  logic                             progWrite,
  input  logic [$clog2(`PROG_DEPTH)-1:0]   progAddr,
  input  phaseCpuPkg::instr_t              progData,
  input  phaseCpuPkg::word_t               portIn,
  output phaseCpuPkg::word_t               portOut,
  output logic                             portWrite
);
  import phaseCpuPkg::*;

  phase_t    phase;       // shared phase ring
  instr_t    instr;       // latched in phase 0
  regAddr_t  wAddr;
  regAddr_t  rAddr;
  dataAddr_t dAddr;
  logic      regDat;
  logic      regOp;
  logic      rdNwrt;
  opcode_t   aluControl;
  word_t     opA;
  word_t     opB;         // also the store data
  word_t     result;
  word_t     dataWord;    // memory or port read
  flags_t    flags;

  // fetch, pc and phase sequencing
  fetchUnit i_fetch (
    .clk(clk), .rst(rst), .run(run),
    .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .flags(flags), .phase(phase), .instr(instr)
  );

  decodeUnit i_decode (
    .clk(clk), .rst(rst), .phase(phase), .instr(instr),
    .wAddr(wAddr), .rAddr(rAddr), .dAddr(dAddr),
    .regDat(regDat), .regOp(regOp), .rdNwrt(rdNwrt), .aluControl(aluControl)
  );

  registerFile i_regs (
    .clk(clk), .phase(phase), .wAddr(wAddr), .rAddr(rAddr),
    .regDat(regDat), .regOp(regOp), .result(result), .dataWord(dataWord),
    .opA(opA), .opB(opB)
  );

  alu i_alu (
    .clk(clk), .rst(rst), .phase(phase), .aluControl(aluControl),
    .opA(opA), .opB(opB), .result(result), .flags(flags)
  );

  // data memory with the port at the top address
  dataMemory i_dmem (
    .clk(clk), .rst(rst), .phase(phase), .dAddr(dAddr), .rdNwrt(rdNwrt),
    .storeData(opB), .portIn(portIn), .dataWord(dataWord),
    .portOut(portOut), .portWrite(portWrite)
  );

endmodule

/* testbench/phaseCpuTests.svh */
`ifndef PHASE_CPU_TESTS_SVH
`define PHASE_CPU_TESTS_SVH

  // one entry per test: name, portIn, slots before the first port write,
  // then the program words and the port outputs expected in order
  task automatic buildTests();
    // port value straight back out
    startTest("port echo", 9'h0A5, 1);
    progWords = {progWords, loadReg(3, Io), storeReg(3, Io), branch(JUMP, 0)};
    expWords = {expWords, 9'h0A5};

    // 200 based arithmetic, all modulo 512
    startTest("arithmetic", 9'h0C8, 3);
    progWords = {progWords,
      loadReg(0, Io), aluOp(COP, 1, 0), aluOp(ADD, 1, 0), storeReg(1, Io),
      aluOp(ADD, 1, 0), storeReg(1, Io), aluOp(SUB, 0, 1), storeReg(0, Io),
      aluOp(INC, 0, 0), storeReg(0, Io), aluOp(DEC, 1, 1), storeReg(1, Io),
      aluOp(MUL, 0, 1), storeReg(0, Io), aluOp(SUB, 1, 0), storeReg(1, Io),
      aluOp(COP, 2, 0), aluOp(DEC, 2, 2), storeReg(2, Io), branch(JUMP, 0)};
    expWords = {expWords, 9'h190, 9'h058, 9'h070, 9'h071, 9'h057, 9'h067, 9'h1F0, 9'h066};

    // bitwise ops, then words parked at 5 and 3 and read back
    startTest("logic and memory", 9'h1B6, 5);
    progWords = {progWords,
      loadReg(0, Io), aluOp(COP, 1, 0), aluOp(ADD, 1, 0), aluOp(COP, 2, 1),
      aluOp(AND, 2, 0), storeReg(2, Io), aluOp(XOR, 1, 0), storeReg(1, Io),
      storeReg(2, 4'h5), storeReg(1, 4'h3), loadReg(4, 4'h5), loadReg(5, 4'h3),
      storeReg(4, Io), aluOp(XOR, 4, 5), storeReg(4, Io), branch(JUMP, 0)};
    expWords = {expWords, 9'h124, 9'h0DA, 9'h124, 9'h1FE};

    // loop until zero, exit path wraps to 0x1FF
    startTest("countdown", 9'h005, 1);
    progWords = {progWords,
      loadReg(0, Io), storeReg(0, Io), aluOp(DEC, 0, 0), branch(JZ, 3),
      storeReg(0, Io), branch(JUMP, -3), aluOp(DEC, 0, 0), storeReg(0, Io),
      branch(JUMP, 0)};
    expWords = {expWords, 9'h005, 9'h004, 9'h003, 9'h002, 9'h001, 9'h1FF};

    // 3 against -2 and back, a wrong branch stores 0x1FE
    startTest("signed branches", 9'h003, 9);
    progWords = {progWords,
      loadReg(0, Io), aluOp(COP, 1, 0), aluOp(SUB, 1, 0), aluOp(DEC, 1, 1),
      aluOp(DEC, 1, 1), aluOp(COP, 2, 0), aluOp(SUB, 2, 1), branch(JL, 3),
      storeReg(2, Io), branch(JG, 2), storeReg(1, Io), aluOp(COP, 3, 1),
      aluOp(SUB, 3, 0), branch(JG, 3), storeReg(3, Io), branch(JL, 2),
      storeReg(1, Io), storeReg(0, Io), branch(JUMP, 0)};
    expWords = {expWords, 9'h005, 9'h1FB, 9'h003};

    startTest("forward jump", 9'h07E, 4);   // the raw 0x07E store is jumped over
    progWords = {progWords,
      loadReg(0, Io), branch(JUMP, 2), storeReg(0, Io), aluOp(INC, 0, 0),
      aluOp(INC, 0, 0), storeReg(0, Io), branch(JUMP, 0)};
    expWords = {expWords, 9'h080};
  endtask

`endif

/* testbench/phaseCpuTb.sv */
`timescale 1ns/1ps
`include "phaseCpu_config.svh"

module phaseCpuTb;
  import phaseCpuPkg::*;

  localparam int ClkPeriod = 20;
  localparam int SlotCycles = `PHASE_COUNT;
  localparam int StoreLatency = 4;              // port write seen 4 cycles into its slot
  localparam int BudgetSlots = 40;              // slots allowed per expected output
  localparam int QuietSlots = 4;                // stray write window after the last one
  localparam int SetupCycles = `PROG_DEPTH + 40;  // reset, load and quiet time per test
  localparam int ProgAddrBits = $clog2(`PROG_DEPTH);
  localparam dataAddr_t Io = `PORT_ADDR;

  logic                    clk;
  logic                    rst;
  logic                    run;
  logic                    progWrite;
  logic [ProgAddrBits-1:0] progAddr;
  instr_t                  progData;
  word_t                   portIn;
  word_t                   portOut;
  logic                    portWrite;

  // test table as flat word lists indexed by per-test start
  string  testNames [$];
  word_t  portValues [$];
  pc_t    firstSlots [$];   // slots before the first port write
  int     progStarts [$];
  int     expStarts [$];
  instr_t progWords [$];
  word_t  expWords [$];

  int     errors;           // current test only
  int     passCount;
  int     failCount;
  bit     tableReady = 1'b0;
  longint limit;            // watchdog limit in cycles

  phaseCpu i_dut (
    .clk(clk), .rst(rst), .run(run),
    .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .portIn(portIn), .portOut(portOut), .portWrite(portWrite)
  );

  // instruction encoders following the field layout
  function automatic instr_t aluOp(opcode_t op, regAddr_t w, regAddr_t r);
    return {op, 1'b0, w, 1'b1, r, 4'h0, 1'b0, 1'b1, 1'b1, 5'h0};   // result back into w
  endfunction

  function automatic instr_t loadReg(regAddr_t w, dataAddr_t addr);
    return {LD, 1'b0, w, 1'b0, 3'h0, addr, 1'b0, 1'b1, 1'b1, 5'h0};
  endfunction

  function automatic instr_t storeReg(regAddr_t r, dataAddr_t addr);
    return {NOP, 1'b0, 3'h0, 1'b0, r, addr, 1'b0, 1'b0, 1'b0, 5'h0};   // store data is operand b
  endfunction

  function automatic instr_t branch(opcode_t op, pc_t offset);
    return {op, offset, 12'h0};
  endfunction

  task automatic startTest(string name, word_t inValue, pc_t slots);
    testNames.push_back(name);
    portValues.push_back(inValue);
    firstSlots.push_back(slots);
    progStarts.push_back(progWords.size());
    expStarts.push_back(expWords.size());
  endtask

  function automatic int progLength(int t);
    return (t + 1 < progStarts.size() ? progStarts[t + 1] : progWords.size()) - progStarts[t];
  endfunction

  function automatic int outputCount(int t);
    return (t + 1 < expStarts.size() ? expStarts[t + 1] : expWords.size()) - expStarts[t];
  endfunction

  `include "phaseCpuTests.svh"

  task automatic checkWord(string signal, word_t got, word_t expected);
    if (got !== expected)
    begin
      $display("Mismatch %s: got %h, expected %h", signal, got, expected);
      errors++;
    end
  endtask

  task automatic checkSlots(string signal, pc_t got, pc_t expected);
    if (got !== expected)
    begin
      $display("Mismatch %s: got %h, expected %h", signal, got, expected);
      errors++;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic resetDut();
    @(posedge clk);
    rst <= 1'b1;
    run <= 1'b0;   // also parks the phase ring for loading
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic loadProgram(int t);
    for (int i = 0; i < progLength(t); i++)
    begin
      @(posedge clk);
      progWrite <= 1'b1;
      progAddr  <= ProgAddrBits'(i);
      progData  <= progWords[progStarts[t] + i];
    end
    @(posedge clk);
    progWrite <= 1'b0;
  endtask

  task automatic runTest(int t);
    int cycles;
    int seen;
    int expected;
    int budget;
    expected = outputCount(t);
    budget = expected * BudgetSlots * SlotCycles;
    errors = 0;
    seen = 0;
    cycles = 0;
    resetDut();
    loadProgram(t);
    portIn <= portValues[t];
    @(posedge clk);
    run <= 1'b1;   // slot 0 starts here
    while (seen < expected && cycles < budget)
    begin
      @(posedge clk);
      cycles++;
      @(negedge clk);   // sample mid cycle
      if (portWrite)
      begin
        if (seen == 0)
        begin
          if ((cycles - StoreLatency) % SlotCycles != 0)
          begin
            $display("%s: first port write came %0d cycles after run, off the store phase",
                     testNames[t], cycles);
            errors++;
          end
          checkSlots($sformatf("first write slot (%s)", testNames[t]),
                     pc_t'((cycles - StoreLatency) / SlotCycles), firstSlots[t]);
        end
        checkWord($sformatf("portOut (%s, write %0d)", testNames[t], seen),
                  portOut, expWords[expStarts[t] + seen]);
        seen++;
      end
    end
    if (seen < expected)
    begin
      $display("%s: only %0d of %0d port writes arrived within %0d cycles",
               testNames[t], seen, expected, budget);
      errors++;
    end
    // a skipped store leaking out shows up here
    repeat (QuietSlots * SlotCycles)
    begin
      @(negedge clk);
      if (portWrite)
      begin
        $display("%s: unexpected extra port write of %h", testNames[t], portOut);
        errors++;
      end
    end
    if (errors == 0)
      passCount++;
    else
      failCount++;
    $display("test %0d %s: %s, %0d errors", t, testNames[t], errors == 0 ? "pass" : "fail",
             errors);
  endtask

  initial
  begin
    rst = 1'b1;
    run = 1'b0;
    progWrite = 1'b0;
    progAddr = '0;
    progData = '0;
    portIn = '0;
    passCount = 0;
    failCount = 0;
    buildTests();
    tableReady = 1'b1;
    for (int t = 0; t < testNames.size(); t++)
      runTest(t);
    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog sized from the table
  initial
  begin
    wait (tableReady);
    limit = 0;
    for (int t = 0; t < testNames.size(); t++)
      limit += outputCount(t) * BudgetSlots * SlotCycles + SetupCycles;
    #(limit * ClkPeriod);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* phaseCpu.f */
+incdir+common
+incdir+testbench
common/phaseCpuPkg.sv
fetch/fetchUnit.sv
rtl/decodeUnit.sv
datapath/registerFile.sv
datapath/alu.sv
datapath/dataMemory.sv
rtl/phaseCpu.sv
testbench/phaseCpuTb.sv
